//--- Bender.yml
package:
  name: adc_frontend

sources:
  - adc_ctl_pkg.sv
  - adc_rx_pkg.sv
  - spi_byte_shifter.sv
  - adc_reg_writer.sv
  - adc_init_sequencer.sv
  - rx_bitslip_gearbox.sv
  - rx_frame_aligner.sv
  - adc_frontend.sv
  - target: simulation
    files:
      - tb_adc_frontend.sv

//--- adc_ctl_pkg.sv
package adc_ctl_pkg;

	// Microcode step period in slow_clk cycles
	localparam int step_cycles     = 64;
	localparam int step_bits       = $clog2(step_cycles);

	// SPI clock half period in slow_clk cycles
	localparam int spi_half_cycles = 2;
	localparam int spi_div_bits    = $clog2(spi_half_cycles);

	// Register write fields
	localparam int reg_addr_bits   = 8;
	localparam int reg_value_bits  = 16;

	localparam int ucode_len       = 15;
	localparam int ucode_ptr_bits  = $clog2(ucode_len);

	// One line of power-on microcode
	typedef struct packed {
		logic                      wr;
		logic [reg_addr_bits-1:0]  addr;
		logic [reg_value_bits-1:0] value;
		logic                      rst_n;
		logic                      pd;
	} ucode_step_t;

	// Fields are wr, addr, value, rst_n, pd
	localparam ucode_step_t ucode_table [ucode_len] = '{
		'{1'b0, 8'h00, 16'h0000, 1'b0, 1'b0},
		'{1'b0, 8'h00, 16'h0000, 1'b1, 1'b0},
		'{1'b0, 8'h00, 16'h0000, 1'b1, 1'b1},
		'{1'b0, 8'h00, 16'h0000, 1'b1, 1'b0},
		'{1'b1, 8'h31, 16'h0001, 1'b1, 1'b0},
		'{1'b0, 8'h00, 16'h0000, 1'b1, 1'b1},
		'{1'b0, 8'h00, 16'h0000, 1'b1, 1'b0},
		'{1'b1, 8'h3a, 16'h0202, 1'b1, 1'b0},
		'{1'b1, 8'h3b, 16'h0202, 1'b1, 1'b0},
		'{1'b1, 8'h53, 16'h0000, 1'b1, 1'b0},
		'{1'b0, 8'h00, 16'h0000, 1'b1, 1'b1},
		'{1'b0, 8'h00, 16'h0000, 1'b1, 1'b0},
		'{1'b1, 8'h56, 16'h0008, 1'b1, 1'b0},
		'{1'b1, 8'h30, 16'h00ff, 1'b1, 1'b0},
		'{1'b0, 8'h00, 16'h0000, 1'b1, 1'b0}
	};

	// Register writer FSM
	typedef enum logic [2:0] {
		idle,
		send_addr,
		send_hi,
		send_lo,
		finish
	} writer_state_t;

endpackage

//--- adc_frontend.sv
`timescale 1ns/1ns

module adc_frontend import adc_ctl_pkg::*, adc_rx_pkg::*; (
	input  logic                            slow_clk,
	input  logic                            rst_done_sync,
	input  logic [word_bits-1:0]            raw_frame,
	input  logic [lane_count*word_bits-1:0] raw_lanes,
	output logic                            spi_clk,
	output logic                            spi_data,
	output logic                            spi_cs_n,
	output logic                            adc_rst_n,
	output logic                            adc_pd,
	output logic                            init_done,
	output logic [lane_count*word_bits-1:0] sample_data,
	output logic                            sample_valid
);

	logic                            reg_wr;
	logic [reg_addr_bits-1:0]        reg_addr;
	logic [reg_value_bits-1:0]       reg_value;
	logic                            reg_done;
	logic                            flush;
	logic                            bitslip;
	logic [word_bits-1:0]            frame_word;
	logic [lane_count*word_bits-1:0] lane_words;

	//////////////////////////////////////////////////////////////////////
	// Configuration path

	adc_init_sequencer u_seq (
		.slow_clk      (slow_clk),
		.rst_done_sync (rst_done_sync),
		.reg_done      (reg_done),
		.reg_wr        (reg_wr),
		.reg_addr      (reg_addr),
		.reg_value     (reg_value),
		.adc_rst_n     (adc_rst_n),
		.adc_pd        (adc_pd),
		.init_done     (init_done)
	);

	adc_reg_writer u_writer (
		.slow_clk      (slow_clk),
		.rst_done_sync (rst_done_sync),
		.reg_wr        (reg_wr),
		.reg_addr      (reg_addr),
		.reg_value     (reg_value),
		.reg_done      (reg_done),
		.spi_clk       (spi_clk),
		.spi_data      (spi_data),
		.spi_cs_n      (spi_cs_n)
	);

	//////////////////////////////////////////////////////////////////////
	// Receive path

	rx_bitslip_gearbox u_gearbox (
		.slow_clk      (slow_clk),
		.rst_done_sync (rst_done_sync),
		.flush         (flush),
		.bitslip       (bitslip),
		.raw_frame     (raw_frame),
		.raw_lanes     (raw_lanes),
		.frame_word    (frame_word),
		.lane_words    (lane_words)
	);

	rx_frame_aligner u_aligner (
		.slow_clk      (slow_clk),
		.rst_done_sync (rst_done_sync),
		.init_done     (init_done),
		.frame_word    (frame_word),
		.lane_words    (lane_words),
		.flush         (flush),
		.bitslip       (bitslip),
		.sample_data   (sample_data),
		.sample_valid  (sample_valid)
	);

endmodule

//--- adc_frontend_input.txt
// One test per line: bit offset, sample count, expected lock (1 = locks)
// All values hex; each offset differs from the line before it
0 40 1
3 30 1
1 60 1
6 20 1
2 80 1
7 40 1
5 30 1
4 50 1
0 20 1
5 40 1
2 100 1
1 30 1

//--- adc_init_sequencer.sv
`timescale 1ns/1ns

module adc_init_sequencer import adc_ctl_pkg::*; (
	input  logic                      slow_clk,
	input  logic                      rst_done_sync,
	input  logic                      reg_done,
	output logic                      reg_wr,
	output logic [reg_addr_bits-1:0]  reg_addr,
	output logic [reg_value_bits-1:0] reg_value,
	output logic                      adc_rst_n,
	output logic                      adc_pd,
	output logic                      init_done
);

	logic [step_bits-1:0]      step_cnt;
	logic [ucode_ptr_bits-1:0] step_ptr;
	logic                      steps_pending;
	logic                      step_tick;
	logic                      wr_pend;
	logic                      wr_busy;
	ucode_step_t               cur_step;

	assign cur_step  = ucode_table[step_ptr];
	assign step_tick = steps_pending && (step_cnt == step_bits'(step_cycles - 1));

	//////////////////////////////////////////////////////////////////////
	// Step timer and table walk

	always_ff @(posedge slow_clk) begin
		if (rst_done_sync) begin
			step_cnt      <= '0;
			step_ptr      <= '0;
			steps_pending <= 1'b1;
			adc_rst_n     <= 1'b1;
			adc_pd        <= 1'b0;
		end else if (steps_pending) begin
			step_cnt <= step_cnt + 1'b1;
			if (step_tick) begin
				step_cnt  <= '0;
				adc_rst_n <= cur_step.rst_n;
				adc_pd    <= cur_step.pd;
				// Table pointer parks on the last line
				if (step_ptr == ucode_ptr_bits'(ucode_len - 1)) begin
					steps_pending <= 1'b0;
				end else begin
					step_ptr <= step_ptr + 1'b1;
				end
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Write requests

	// Back-to-back write steps outrun the SPI link,
	// so a step's write waits here until the writer is free
	always_ff @(posedge slow_clk) begin
		reg_wr <= 1'b0;
		if (rst_done_sync) begin
			wr_pend <= 1'b0;
			wr_busy <= 1'b0;
		end else begin
			if (step_tick && cur_step.wr) begin
				reg_addr  <= cur_step.addr;
				reg_value <= cur_step.value;
				wr_pend   <= 1'b1;
			end else if (wr_pend && !wr_busy) begin
				reg_wr  <= 1'b1;
				wr_busy <= 1'b1;
				wr_pend <= 1'b0;
			end
			if (reg_done) begin
				wr_busy <= 1'b0;
			end
		end
	end

	// Done once the table has run and the last write is out
	always_ff @(posedge slow_clk) begin
		if (rst_done_sync) begin
			init_done <= 1'b0;
		end else if (!steps_pending && !wr_pend && !wr_busy) begin
			init_done <= 1'b1;
		end
	end

endmodule

//--- adc_reg_writer.sv
`timescale 1ns/1ns

module adc_reg_writer import adc_ctl_pkg::*; (
	input  logic                      slow_clk,
	input  logic                      rst_done_sync,
	input  logic                      reg_wr,
	input  logic [reg_addr_bits-1:0]  reg_addr,
	input  logic [reg_value_bits-1:0] reg_value,
	output logic                      reg_done,
	output logic                      spi_clk,
	output logic                      spi_data,
	output logic                      spi_cs_n
);

	writer_state_t             state;
	logic [reg_addr_bits-1:0]  addr_q;
	logic [reg_value_bits-1:0] value_q;
	logic                      shift_en;
	logic [7:0]                tx_byte;
	logic                      shift_done;

	spi_byte_shifter u_shifter (
		.slow_clk      (slow_clk),
		.rst_done_sync (rst_done_sync),
		.shift_en      (shift_en),
		.tx_byte       (tx_byte),
		.spi_clk       (spi_clk),
		.spi_data      (spi_data),
		.shift_done    (shift_done)
	);

	//////////////////////////////////////////////////////////////////////
	// Address byte, then value high, then value low

	always_ff @(posedge slow_clk) begin
		shift_en <= 1'b0;
		reg_done <= 1'b0;
		if (rst_done_sync) begin
			state    <= idle;
			spi_cs_n <= 1'b1;
		end else begin
			case (state)
				idle: begin
					if (reg_wr) begin
						addr_q   <= reg_addr;
						value_q  <= reg_value;
						spi_cs_n <= 1'b0;
						state    <= send_addr;
					end
				end
				send_addr: begin
					shift_en <= 1'b1;
					tx_byte  <= addr_q;
					state    <= send_hi;
				end
				// Each byte starts right after the previous one ends
				send_hi: begin
					if (shift_done) begin
						shift_en <= 1'b1;
						tx_byte  <= value_q[15:8];
						state    <= send_lo;
					end
				end
				send_lo: begin
					if (shift_done) begin
						shift_en <= 1'b1;
						tx_byte  <= value_q[7:0];
						state    <= finish;
					end
				end
				finish: begin
					if (shift_done) begin
						spi_cs_n <= 1'b1;
						reg_done <= 1'b1;
						state    <= idle;
					end
				end
				default: state <= idle;
			endcase
		end
	end

endmodule

//--- adc_rx_pkg.sv
package adc_rx_pkg;

	// Lane geometry
	localparam int lane_count = 8;
	localparam int word_bits  = 8;
	localparam int slip_bits  = $clog2(word_bits);

	// Frame clock word after pin-swap inversion
	// First half of the sample high, second half low
	localparam logic [word_bits-1:0] frame_pattern = 8'h0f;

	// Phase error window
	localparam int window_cycles  = 256;
	localparam int win_bits       = $clog2(window_cycles);
	localparam int err_bits       = $clog2(window_cycles + 1);
	localparam int slip_threshold = 16;

	// Gearbox flush after init
	localparam int flush_cycles = 3;
	localparam int flush_bits   = $clog2(flush_cycles);

	// Aligner FSM
	typedef enum logic [1:0] {
		wait_init,
		flushing,
		track
	} aligner_state_t;

endpackage

//--- build.f
adc_ctl_pkg.sv
adc_rx_pkg.sv
spi_byte_shifter.sv
adc_reg_writer.sv
adc_init_sequencer.sv
rx_bitslip_gearbox.sv
rx_frame_aligner.sv
adc_frontend.sv
tb_adc_frontend.sv

//--- rx_bitslip_gearbox.sv
`timescale 1ns/1ns

module rx_bitslip_gearbox import adc_rx_pkg::*; (
	input  logic                            slow_clk,
	input  logic                            rst_done_sync,
	input  logic                            flush,
	input  logic                            bitslip,
	input  logic [word_bits-1:0]            raw_frame,
	input  logic [lane_count*word_bits-1:0] raw_lanes,
	output logic [word_bits-1:0]            frame_word,
	output logic [lane_count*word_bits-1:0] lane_words
);

	// Frame clock is channel 0, lanes follow
	localparam int chan_bits = (lane_count + 1) * word_bits;

	logic [chan_bits-1:0]   raw_all;
	logic [chan_bits-1:0]   prev_all;
	logic [chan_bits-1:0]   next_all;
	logic [chan_bits-1:0]   out_all;
	logic [2*word_bits-1:0] hist [lane_count+1];
	logic [slip_bits-1:0]   slip;

	assign raw_all = {raw_lanes, raw_frame};

	// Slip offset and previous word per channel
	always_ff @(posedge slow_clk) begin
		if (rst_done_sync || flush) begin
			slip     <= '0;
			prev_all <= '0;
		end else begin
			prev_all <= raw_all;
			if (bitslip) begin
				slip <= slip + 1'b1;
			end
		end
	end

	// Previous word is older, bit 7 is the oldest bit of each word
	// Window ends slip bits before the newest bit
	// Inverted for the swapped pins
	for (genvar g = 0; g <= lane_count; g++) begin : g_chan
		assign hist[g] = {prev_all[g*word_bits +: word_bits], raw_all[g*word_bits +: word_bits]};
		assign next_all[g*word_bits +: word_bits] = ~hist[g][slip +: word_bits];
	end

	always_ff @(posedge slow_clk) begin
		out_all <= next_all;
	end

	assign frame_word = out_all[word_bits-1:0];
	assign lane_words = out_all[chan_bits-1:word_bits];

endmodule

//--- rx_frame_aligner.sv
`timescale 1ns/1ns

module rx_frame_aligner import adc_rx_pkg::*; (
	input  logic                            slow_clk,
	input  logic                            rst_done_sync,
	input  logic                            init_done,
	input  logic [word_bits-1:0]            frame_word,
	input  logic [lane_count*word_bits-1:0] lane_words,
	output logic                            flush,
	output logic                            bitslip,
	output logic [lane_count*word_bits-1:0] sample_data,
	output logic                            sample_valid
);

	aligner_state_t        state;
	logic [flush_bits-1:0] flush_cnt;
	logic [win_bits-1:0]   win_cnt;
	logic [err_bits-1:0]   err_cnt;
	logic [err_bits-1:0]   err_total;
	logic                  frame_err;

	// Error count including the current cycle
	assign frame_err = (frame_word != frame_pattern);
	assign err_total = err_cnt + err_bits'(frame_err);

	// Gearbox output is already registered
	assign sample_data = lane_words;

	//////////////////////////////////////////////////////////////////////
	// Flush, then per-window phase check

	always_ff @(posedge slow_clk) begin
		bitslip <= 1'b0;
		if (rst_done_sync) begin
			state        <= wait_init;
			flush        <= 1'b0;
			flush_cnt    <= '0;
			win_cnt      <= '0;
			err_cnt      <= '0;
			sample_valid <= 1'b0;
		end else begin
			case (state)
				wait_init: begin
					if (init_done) begin
						flush     <= 1'b1;
						flush_cnt <= '0;
						state     <= flushing;
					end
				end
				flushing: begin
					flush_cnt <= flush_cnt + 1'b1;
					if (flush_cnt == flush_bits'(flush_cycles - 1)) begin
						flush   <= 1'b0;
						win_cnt <= '0;
						err_cnt <= '0;
						state   <= track;
					end
				end
				track: begin
					win_cnt <= win_cnt + 1'b1;
					err_cnt <= err_total;
					// Window end: slip and drop lock, or declare lock
					if (win_cnt == win_bits'(window_cycles - 1)) begin
						win_cnt <= '0;
						err_cnt <= '0;
						if (err_total > err_bits'(slip_threshold)) begin
							bitslip      <= 1'b1;
							sample_valid <= 1'b0;
						end else begin
							sample_valid <= 1'b1;
						end
					end
				end
				default: state <= wait_init;
			endcase
		end
	end

endmodule

//--- spi_byte_shifter.sv
`timescale 1ns/1ns

module spi_byte_shifter import adc_ctl_pkg::*; (
	input  logic       slow_clk,
	input  logic       rst_done_sync,
	input  logic       shift_en,
	input  logic [7:0] tx_byte,
	output logic       spi_clk,
	output logic       spi_data,
	output logic       shift_done
);

	logic                    busy;
	logic [spi_div_bits-1:0] div_cnt;
	logic [2:0]              bit_cnt;
	logic [7:0]              shift_reg;
	logic                    half_end;

	// Last slow_clk cycle of an SPI half period
	assign half_end = busy && (div_cnt == spi_div_bits'(spi_half_cycles - 1));

	// MSB out first, data line parked low when idle
	assign spi_data = busy & shift_reg[7];

	//////////////////////////////////////////////////////////////////////
	// Bit timing

	always_ff @(posedge slow_clk) begin
		shift_done <= 1'b0;
		if (rst_done_sync) begin
			busy    <= 1'b0;
			spi_clk <= 1'b0;
			div_cnt <= '0;
			bit_cnt <= '0;
		end else if (!busy) begin
			if (shift_en) begin
				busy    <= 1'b1;
				spi_clk <= 1'b0;
				div_cnt <= '0;
				bit_cnt <= '0;
			end
		end else begin
			div_cnt <= div_cnt + 1'b1;
			if (half_end) begin
				div_cnt <= '0;
				spi_clk <= !spi_clk;
				// High phase over, bit is finished
				if (spi_clk) begin
					bit_cnt <= bit_cnt + 1'b1;
					if (bit_cnt == 3'd7) begin
						busy       <= 1'b0;
						shift_done <= 1'b1;
					end
				end
			end
		end
	end

	// Load on start, advance on each falling SPI edge
	always_ff @(posedge slow_clk) begin
		if (!busy && shift_en) begin
			shift_reg <= tx_byte;
		end else if (half_end && spi_clk) begin
			shift_reg <= {shift_reg[6:0], 1'b0};
		end
	end

endmodule

//--- tb_adc_frontend.sv
`timescale 1ns/1ns

module tb_adc_frontend import adc_ctl_pkg::*, adc_rx_pkg::*; ();

	localparam int clk_period  = 100;
	localparam int max_tests   = 16;
	localparam int init_cycles = step_cycles * (ucode_len + 4);
	localparam int lock_limit  = 20 * window_cycles;
	localparam int loss_limit  = 2 * window_cycles + 8;
	localparam int queue_depth = 32;

	logic                            slow_clk;
	logic                            rst_done_sync;
	logic [word_bits-1:0]            raw_frame;
	logic [lane_count*word_bits-1:0] raw_lanes;
	logic                            spi_clk;
	logic                            spi_data;
	logic                            spi_cs_n;
	logic                            adc_rst_n;
	logic                            adc_pd;
	logic                            init_done;
	logic [lane_count*word_bits-1:0] sample_data;
	logic                            sample_valid;

	// Stream generator
	logic [31:0]                     lcg_state;
	logic [2:0]                      offset;
	logic [lane_count*word_bits-1:0] prev_samples;
	logic [lane_count*word_bits-1:0] exp_q [$];
	logic [15:0]                     test_mem [3*max_tests];

	// Monitor state
	logic        in_reset;
	logic        spi_clk_q;
	logic        cs_n_q;
	logic        rst_n_q;
	logic        pd_q;
	logic        init_q;
	logic [31:0] frame_bits;
	int          cyc;
	int          frame_len;
	int          frame_cnt;
	int          spi_ptr;
	int          rst_ptr;
	int          pd_ptr;
	int          rst_changes;
	int          pd_changes;
	int          init_rises;
	int          err_cnt;
	int          tests_failed;

	adc_frontend DUT (
		.slow_clk      (slow_clk),
		.rst_done_sync (rst_done_sync),
		.raw_frame     (raw_frame),
		.raw_lanes     (raw_lanes),
		.spi_clk       (spi_clk),
		.spi_data      (spi_data),
		.spi_cs_n      (spi_cs_n),
		.adc_rst_n     (adc_rst_n),
		.adc_pd        (adc_pd),
		.init_done     (init_done),
		.sample_data   (sample_data),
		.sample_valid  (sample_valid)
	);

	initial begin
		slow_clk = 1'b0;
		forever #(clk_period / 2) slow_clk = ~slow_clk;
	end

	//////////////////////////////////////////////////////////////////////
	// Helpers

	task automatic check_value(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		if (got !== exp) begin
			$display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
			err_cnt++;
		end
	endtask

	task automatic note_failure(input string msg);
		$display("ERROR %0t %s", $time, msg);
		err_cnt++;
	endtask

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic step_pin(input int idx, input bit pd_pin);
		return pd_pin ? ucode_table[idx].pd : ucode_table[idx].rst_n;
	endfunction

	// Level changes of one pin across the table from its reset level
	function automatic int count_changes(input bit pd_pin);
		logic level;
		int   n;
		level = pd_pin ? 1'b0 : 1'b1;
		n = 0;
		for (int i = 0; i < ucode_len; i++) begin
			if (step_pin(i, pd_pin) !== level) begin
				n++;
				level = step_pin(i, pd_pin);
			end
		end
		return n;
	endfunction

	function automatic int count_writes();
		int n;
		n = 0;
		for (int i = 0; i < ucode_len; i++) begin
			if (ucode_table[i].wr) begin
				n++;
			end
		end
		return n;
	endfunction

	// Frame must be the next write line of the table
	task automatic check_frame();
		while (spi_ptr < ucode_len && !ucode_table[spi_ptr].wr) begin
			spi_ptr++;
		end
		if (spi_ptr >= ucode_len) begin
			note_failure("SPI frame seen with no write step left in the table");
		end else begin
			check_value("spi_frame_len", frame_len, 24);
			check_value("spi_frame", frame_bits[23:0],
				{ucode_table[spi_ptr].addr, ucode_table[spi_ptr].value});
			spi_ptr++;
		end
		frame_cnt++;
	endtask

	// Next line that changes the pin applies at 64 cycles per step
	task automatic check_pin(input string name, input bit pd_pin, input logic new_level,
			inout int ptr);
		logic level;
		// Pin level the table holds after its last change
		level = (ptr == 0) ? (pd_pin ? 1'b0 : 1'b1) : step_pin(ptr - 1, pd_pin);
		while (ptr < ucode_len && step_pin(ptr, pd_pin) === level) begin
			ptr++;
		end
		if (ptr >= ucode_len) begin
			note_failure({name, " changed with no table step left that changes it"});
		end else begin
			check_value(name, new_level, step_pin(ptr, pd_pin));
			check_value({name, "_cycle"}, cyc, step_cycles * (ptr + 1));
			ptr++;
		end
	endtask

	// Find the first aligned word in the stream and follow it
	task automatic check_samples(input int count);
		int idx;
		int n;
		idx = -1;
		for (int i = 0; i < exp_q.size(); i++) begin
			if (idx < 0 && exp_q[i] === sample_data) begin
				idx = i;
			end
		end
		if (idx < 0) begin
			note_failure("first aligned sample is not in the expected stream");
			return;
		end
		repeat (idx) exp_q.delete(0);
		n = 0;
		while (n < count) begin
			if (!sample_valid) begin
				note_failure("sample_valid fell while aligned samples were checked");
				break;
			end
			check_value("sample_data", sample_data, exp_q.pop_front());
			n++;
			@(negedge slow_clk);
		end
	endtask

	task automatic run_watchdog(input int n);
		#((init_cycles + n * lock_limit) * clk_period);
		$display("ERROR %0t watchdog expired before the tests completed", $time);
		$display("Simulation finished: FAIL");
		$finish;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Serial stream per channel chopped at the current bit offset

	always @(posedge slow_clk) begin : drive_stream
		logic [lane_count*word_bits-1:0] cur;
		logic [lane_count*word_bits-1:0] raw_l;
		logic [2*word_bits-1:0]          hist;
		lcg_state = lcg_next(lcg_state);
		cur[31:0] = lcg_state;
		lcg_state = lcg_next(lcg_state);
		cur[63:32] = lcg_state;
		// Older sample on top and MSB first on the wire
		for (int i = 0; i < lane_count; i++) begin
			hist = {prev_samples[i*word_bits +: word_bits], cur[i*word_bits +: word_bits]};
			raw_l[i*word_bits +: word_bits] = hist[offset +: word_bits];
		end
		hist = {8'hf0, 8'hf0};
		raw_frame <= hist[offset +: word_bits];
		raw_lanes <= raw_l;
		prev_samples = cur;
		// Board swaps pins so aligned output is the complement
		exp_q.push_back(~cur);
		if (exp_q.size() > queue_depth) begin
			exp_q.delete(0);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// SPI decode, pin order and init completion

	always @(negedge slow_clk) begin
		if (rst_done_sync) begin
			in_reset = 1'b1;
		end else if (in_reset) begin
			in_reset = 1'b0;
			cyc = 0;
			check_value("spi_cs_n", spi_cs_n, 1'b1);
			check_value("spi_clk", spi_clk, 1'b0);
			check_value("adc_rst_n", adc_rst_n, 1'b1);
			check_value("adc_pd", adc_pd, 1'b0);
			check_value("init_done", init_done, 1'b0);
			check_value("sample_valid", sample_valid, 1'b0);
		end else begin
			cyc++;
			if (cs_n_q && !spi_cs_n) begin
				frame_bits = '0;
				frame_len  = 0;
			end
			// Data is stable at the rising SPI edge
			if (!spi_cs_n && !spi_clk_q && spi_clk) begin
				frame_bits = {frame_bits[30:0], spi_data};
				frame_len++;
			end
			if (!cs_n_q && spi_cs_n) begin
				check_frame();
			end
			if (adc_rst_n !== rst_n_q) begin
				check_pin("adc_rst_n", 1'b0, adc_rst_n, rst_ptr);
				rst_changes++;
			end
			if (adc_pd !== pd_q) begin
				check_pin("adc_pd", 1'b1, adc_pd, pd_ptr);
				pd_changes++;
			end
			if (init_done && !init_q) begin
				init_rises++;
				check_value("spi_frames_at_init_done", frame_cnt, count_writes());
				check_value("spi_cs_n_at_init_done", spi_cs_n, 1'b1);
			end
			if (!init_done && init_q) begin
				note_failure("init_done fell after it had risen");
			end
			if (!init_done && sample_valid) begin
				note_failure("sample_valid went high before init_done");
			end
		end
		spi_clk_q = spi_clk;
		cs_n_q    = spi_cs_n;
		rst_n_q   = adc_rst_n;
		pd_q      = adc_pd;
		init_q    = init_done;
	end

	//////////////////////////////////////////////////////////////////////
	// Test sequence

	initial begin : main_flow
		int          n_tests;
		int          fails_before;
		int          waited;
		logic        got_lock;
		logic [15:0] t_off;
		logic [15:0] t_cnt;
		logic [15:0] t_lock;
		rst_done_sync = 1'b1;
		raw_frame     = '0;
		raw_lanes     = '0;
		offset        = '0;
		prev_samples  = '0;
		lcg_state     = 32'ha5f0_978a;
		in_reset      = 1'b0;
		frame_bits    = '0;
		cyc           = 0;
		frame_len     = 0;
		frame_cnt     = 0;
		spi_ptr       = 0;
		rst_ptr       = 0;
		pd_ptr        = 0;
		rst_changes   = 0;
		pd_changes    = 0;
		init_rises    = 0;
		err_cnt       = 0;
		tests_failed  = 0;
		for (int i = 0; i < 3 * max_tests; i++) begin
			test_mem[i] = '1;
		end
		$readmemh("adc_frontend_input.txt", test_mem);
		n_tests = 0;
		while (n_tests < max_tests && test_mem[3*n_tests] !== 16'hffff) begin
			n_tests++;
		end
		fork
			run_watchdog(n_tests);
		join_none

		repeat (4) @(posedge slow_clk);
		rst_done_sync <= 1'b0;

		waited = 0;
		while (init_done !== 1'b1 && waited < init_cycles) begin
			@(negedge slow_clk);
			waited++;
		end
		if (init_done !== 1'b1) begin
			note_failure("init_done did not rise within the init time");
		end

		for (int t = 0; t < n_tests; t++) begin
			t_off        = test_mem[3*t];
			t_cnt        = test_mem[3*t+1];
			t_lock       = test_mem[3*t+2];
			fails_before = err_cnt;
			@(negedge slow_clk);
			offset = t_off[2:0];
			// A new offset breaks the current lock
			if (sample_valid) begin
				waited = 0;
				while (sample_valid && waited < loss_limit) begin
					@(negedge slow_clk);
					waited++;
				end
				if (sample_valid) begin
					note_failure("sample_valid did not fall within two windows");
				end
			end
			waited = 0;
			while (!sample_valid && waited < lock_limit) begin
				@(negedge slow_clk);
				waited++;
			end
			got_lock = sample_valid;
			check_value("lock", got_lock, t_lock[0]);
			if (got_lock) begin
				check_samples(t_cnt);
			end
			if (err_cnt == fails_before) begin
				$display("test %0d offset %0d samples %0d ok", t, t_off, t_cnt);
			end else begin
				$display("test %0d offset %0d samples %0d failed", t, t_off, t_cnt);
				tests_failed++;
			end
		end

		// Totals over the whole init sequence
		@(posedge slow_clk);
		check_value("spi_frame_count", frame_cnt, count_writes());
		check_value("init_done_rises", init_rises, 1);
		check_value("adc_rst_n_changes", rst_changes, count_changes(1'b0));
		check_value("adc_pd_changes", pd_changes, count_changes(1'b1));
		$display("tests %0d, failed %0d, errors %0d", n_tests, tests_failed, err_cnt);
		if (err_cnt == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule
